// ==== source/rram_pkg.sv ====
package rram_pkg;

	localparam int LINES = 16; // Rows and columns of the crossbar
	localparam int IDX_W = $clog2(LINES);

	typedef logic [31:0] word_t;
	typedef logic [LINES-1:0] vec_t;

	// Host bus region, address bits 29..28
	localparam int REGION_LSB = 28;
	typedef enum logic [1:0] {
		REG_INSTR  = 2'd0,
		REG_RESULT = 2'd1,
		REG_INPUT  = 2'd2,
		REG_NONE   = 2'd3
	} region_t;

	// Opcode, instruction bits 31..28
	localparam int OPCODE_LSB = 28;
	typedef enum logic [3:0] {
		OP_IDLE  = 4'd0,
		OP_READ  = 4'd1,
		OP_WRITE = 4'd2,
		OP_MAC   = 4'd3
	} opcode_t;

	localparam int ROW_LSB       = 4;
	localparam int COL_LSB       = 0;
	localparam int DATA_BIT      = 8; // 1 is SET, 0 is RESET
	localparam int MAC_COUNT_LSB = 4; // Vector count minus one
	localparam int COL_SEL_BIT   = 0; // ADC column half

	typedef enum logic [3:0] {
		PH_IDLE, PH_FETCH, PH_DECODE,
		PH_RD_PRE, PH_RD_WL, PH_RD_SENSE,
		PH_WR_EN, PH_WR_DRIVE, PH_WR_REL,
		PH_MAC_LOAD, PH_MAC_CONV, PH_MAC_STORE,
		PH_DONE
	} phase_t;

endpackage

// ==== source/word_ram.sv ====
module word_ram #(
	parameter type T = logic [31:0],
	parameter int DEPTH = 64
) (
	input  logic                     clk,
	input  logic                     wr_en,
	input  logic [$clog2(DEPTH)-1:0] wr_addr,
	input  T                         wr_data,
	input  logic [$clog2(DEPTH)-1:0] rd_addr,
	output T                         rd_data
);

	T mem [DEPTH];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		rd_data <= mem[rd_addr]; // One cycle read latency
	end

endmodule

// ==== source/host_port.sv ====
module host_port #(
	parameter int PROG_DEPTH = 64,
	parameter int IBUF_DEPTH = 16,
	parameter int RBUF_DEPTH = 64
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          bus_we,
	input  rram_pkg::word_t               bus_addr,
	input  rram_pkg::word_t               bus_wdata,
	output rram_pkg::word_t               bus_rdata,
	input  logic [$clog2(PROG_DEPTH)-1:0] prog_addr,
	output rram_pkg::word_t               prog_data,
	input  logic [$clog2(IBUF_DEPTH)-1:0] ibuf_addr,
	output rram_pkg::vec_t                ibuf_data,
	input  logic                          res_we,
	input  logic [$clog2(RBUF_DEPTH)-1:0] res_addr,
	input  rram_pkg::word_t               res_data
);
	import rram_pkg::*;

	localparam int PA_W = $clog2(PROG_DEPTH);
	localparam int IB_W = $clog2(IBUF_DEPTH);
	localparam int RB_W = $clog2(RBUF_DEPTH);

	region_t region;
	logic prog_we;
	logic ibuf_we;
	logic host_res_we;
	logic rbuf_we;
	logic rd_sel_q;
	logic [RB_W-1:0] rbuf_waddr;
	word_t rbuf_wdata;
	word_t rbuf_q;

	assign region      = region_t'(bus_addr[REGION_LSB +: 2]);
	assign prog_we     = bus_we && (region == REG_INSTR);
	assign ibuf_we     = bus_we && (region == REG_INPUT);
	assign host_res_we = bus_we && (region == REG_RESULT);

	// Sequencer owns the result write port when both want it
	assign rbuf_we    = res_we || host_res_we;
	assign rbuf_waddr = res_we ? res_addr : bus_addr[RB_W-1:0];
	assign rbuf_wdata = res_we ? res_data : bus_wdata;

	word_ram #(.T(word_t), .DEPTH(PROG_DEPTH)) u_prog_mem (
		.clk(clk), .wr_en(prog_we), .wr_addr(bus_addr[PA_W-1:0]), .wr_data(bus_wdata),
		.rd_addr(prog_addr), .rd_data(prog_data)
	);

	word_ram #(.T(vec_t), .DEPTH(IBUF_DEPTH)) u_input_buf (
		.clk(clk), .wr_en(ibuf_we), .wr_addr(bus_addr[IB_W-1:0]),
		.wr_data(bus_wdata[LINES-1:0]), .rd_addr(ibuf_addr), .rd_data(ibuf_data)
	);

	word_ram #(.T(word_t), .DEPTH(RBUF_DEPTH)) u_result_mem (
		.clk(clk), .wr_en(rbuf_we), .wr_addr(rbuf_waddr), .wr_data(rbuf_wdata),
		.rd_addr(bus_addr[RB_W-1:0]), .rd_data(rbuf_q)
	);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rd_sel_q <= 1'b0;
		end else begin
			rd_sel_q <= !bus_we && (region == REG_RESULT);
		end
	end

	assign bus_rdata = rd_sel_q ? rbuf_q : '0; // Zero outside result reads

endmodule

// ==== source/array_sequencer.sv ====
module array_sequencer #(
	parameter int PROG_DEPTH = 64,
	parameter int IBUF_DEPTH = 16,
	parameter int RBUF_DEPTH = 64
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          run,
	output logic                          busy,
	output logic                          done,
	output logic [$clog2(PROG_DEPTH)-1:0] prog_addr,
	input  rram_pkg::word_t               prog_data,
	output logic [$clog2(IBUF_DEPTH)-1:0] ibuf_addr,
	input  rram_pkg::vec_t                ibuf_data,
	output logic                          res_we,
	output logic [$clog2(RBUF_DEPTH)-1:0] res_addr,
	output rram_pkg::word_t               res_data,
	input  rram_pkg::vec_t                csa,
	input  rram_pkg::vec_t                adc_out0,
	input  rram_pkg::vec_t                adc_out1,
	input  rram_pkg::vec_t                adc_out2,
	output rram_pkg::phase_t              phase,
	output logic [rram_pkg::IDX_W-1:0]    row,
	output logic [rram_pkg::IDX_W-1:0]    col,
	output logic                          set_bit,
	output rram_pkg::vec_t                wl_vec,
	output logic                          col_sel
);
	import rram_pkg::*;

	localparam int PA_W = $clog2(PROG_DEPTH);
	localparam int IB_W = $clog2(IBUF_DEPTH);
	localparam int RB_W = $clog2(RBUF_DEPTH);

	logic run_q;
	logic [PA_W-1:0] pc;
	logic [IB_W-1:0] vec_idx;
	logic [IB_W-1:0] mac_cnt;
	logic [RB_W-1:0] res_ptr;
	opcode_t opcode;
	word_t mac_word;
	logic [7:0] half0;
	logic [7:0] half1;
	logic [7:0] half2;

	assign opcode    = opcode_t'(prog_data[OPCODE_LSB +: 4]);
	assign prog_addr = pc;
	assign ibuf_addr = vec_idx;
	assign wl_vec    = ibuf_data; // Valid from MAC_CONV on

	//////////////////////////////////////////////////////////////////////
	// Result words

	assign half0 = col_sel ? adc_out0[15:8] : adc_out0[7:0];
	assign half1 = col_sel ? adc_out1[15:8] : adc_out1[7:0];
	assign half2 = col_sel ? adc_out2[15:8] : adc_out2[7:0];

	// Each nibble is {adc0, adc1, adc2, 1}
	always_comb begin
		mac_word = '0;
		for (int g = 0; g < 8; g++) begin
			mac_word[4*g]   = 1'b1;
			mac_word[4*g+1] = half2[g];
			mac_word[4*g+2] = half1[g];
			mac_word[4*g+3] = half0[g];
		end
	end

	assign res_we   = (phase == PH_RD_SENSE) || (phase == PH_MAC_STORE);
	assign res_addr = res_ptr;
	assign res_data = (phase == PH_MAC_STORE) ? mac_word : word_t'(csa);

	//////////////////////////////////////////////////////////////////////
	// Phase machine

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			phase   <= PH_IDLE;
			run_q   <= 1'b0;
			busy    <= 1'b0;
			done    <= 1'b0;
			pc      <= '0;
			vec_idx <= '0;
			res_ptr <= '0;
		end else begin
			run_q <= run;
			if (res_we) begin
				res_ptr <= res_ptr + 1'b1;
			end
			case (phase)
				PH_IDLE: begin
					if (run && !run_q) begin
						phase   <= PH_FETCH;
						busy    <= 1'b1;
						pc      <= '0;
						res_ptr <= '0;
					end
				end
				PH_FETCH: phase <= PH_DECODE; // Memory read in flight
				PH_DECODE: begin
					pc      <= pc + 1'b1;
					vec_idx <= '0;
					case (opcode)
						OP_READ:  phase <= PH_RD_PRE;
						OP_WRITE: phase <= PH_WR_EN;
						OP_MAC:   phase <= PH_MAC_LOAD;
						default: begin // IDLE and unknown opcodes end the program
							phase <= PH_DONE;
							busy  <= 1'b0;
							done  <= 1'b1;
						end
					endcase
				end
				PH_RD_PRE:   phase <= PH_RD_WL;
				PH_RD_WL:    phase <= PH_RD_SENSE;
				PH_RD_SENSE: phase <= PH_FETCH;
				PH_WR_EN:    phase <= PH_WR_DRIVE;
				PH_WR_DRIVE: phase <= PH_WR_REL;
				PH_WR_REL:   phase <= PH_FETCH;
				PH_MAC_LOAD: phase <= PH_MAC_CONV;
				PH_MAC_CONV: phase <= PH_MAC_STORE;
				PH_MAC_STORE: begin
					vec_idx <= vec_idx + 1'b1;
					phase   <= (vec_idx == mac_cnt) ? PH_FETCH : PH_MAC_LOAD;
				end
				PH_DONE: begin
					if (!run) begin
						phase <= PH_IDLE;
						done  <= 1'b0;
					end
				end
				default: phase <= PH_IDLE;
			endcase
		end
	end

	// Instruction fields, held for the whole instruction
	always_ff @(posedge clk) begin
		if (phase == PH_DECODE) begin
			row     <= prog_data[ROW_LSB +: IDX_W];
			col     <= prog_data[COL_LSB +: IDX_W];
			set_bit <= prog_data[DATA_BIT];
			col_sel <= prog_data[COL_SEL_BIT];
			mac_cnt <= prog_data[MAC_COUNT_LSB +: IB_W];
		end
	end

endmodule

// ==== source/line_driver.sv ====
module line_driver (
	input  logic                       clk,
	input  logic                       rst,
	input  rram_pkg::phase_t           phase,
	input  logic [rram_pkg::IDX_W-1:0] row,
	input  logic [rram_pkg::IDX_W-1:0] col,
	input  logic                       set_bit,
	input  rram_pkg::vec_t             wl_vec,
	input  logic                       col_sel,
	output logic                       enable_csa,
	output logic                       enable_adc,
	output logic                       enable_wl,
	output logic                       enable_sl,
	output logic                       enable_bl,
	output logic                       pre,
	output logic                       saen_csa,
	output logic [1:0]                 clk_en_adc,
	output rram_pkg::vec_t             in0_wl,
	output rram_pkg::vec_t             in1_wl,
	output rram_pkg::vec_t             in0_bl,
	output rram_pkg::vec_t             in1_bl,
	output rram_pkg::vec_t             in0_sl,
	output rram_pkg::vec_t             in1_sl
);
	import rram_pkg::*;

	vec_t sel_row;
	vec_t sel_col;

	assign sel_row = vec_t'(1) << row;
	assign sel_col = vec_t'(1) << col;

	//////////////////////////////////////////////////////////////////////
	// Code 11 grounds a line

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			{enable_csa, enable_adc, enable_wl, enable_sl, enable_bl} <= '0;
			pre        <= 1'b1;
			saen_csa   <= 1'b0;
			clk_en_adc <= '0;
			{in0_wl, in1_wl, in0_bl, in1_bl, in0_sl, in1_sl} <= '1;
		end else begin
			case (phase)
				PH_RD_PRE: begin
					enable_csa <= 1'b1;
					{enable_wl, enable_sl, enable_bl} <= '0;
					pre      <= 1'b0; // Precharge
					saen_csa <= 1'b1;
					in0_bl   <= '0;
					{in1_bl, in0_sl, in1_sl} <= '1;
					in0_wl   <= ~sel_row; // 00 on the row being read
					in1_wl   <= ~sel_row;
				end
				PH_RD_WL: begin
					pre       <= 1'b1;
					enable_wl <= 1'b1;
					enable_bl <= 1'b1;
				end
				PH_RD_SENSE: saen_csa <= 1'b1;
				PH_WR_EN: {enable_wl, enable_sl, enable_bl} <= '1;
				PH_WR_DRIVE: begin
					in0_wl <= ~sel_row; // 01 is the write level
					in1_wl <= '1;
					if (set_bit) begin // SET, bit line 00 and source line grounded
						in0_bl <= ~sel_col;
						in1_bl <= ~sel_col;
						{in0_sl, in1_sl} <= '1;
					end else begin
						{in0_bl, in1_bl} <= '1;
						in0_sl <= ~sel_col; // RESET drives 01 on the source line
						in1_sl <= '1;
					end
				end
				PH_MAC_LOAD: begin
					enable_adc <= 1'b1;
					{enable_wl, enable_sl, enable_bl} <= '0;
					pre        <= 1'b0;
					clk_en_adc <= '0;
					in0_bl     <= '0;
					{in1_bl, in0_sl, in1_sl} <= '1;
				end
				PH_MAC_CONV: begin
					pre        <= 1'b1;
					enable_wl  <= 1'b1;
					enable_bl  <= 1'b1;
					in0_wl     <= ~wl_vec; // Input bit 1 gives 01
					in1_wl     <= '1;
					clk_en_adc <= col_sel ? 2'b10 : 2'b01;
				end
				PH_MAC_STORE: clk_en_adc <= '0;
				default: begin // Park the array
					{enable_csa, enable_adc, enable_wl, enable_sl, enable_bl} <= '0;
					pre        <= 1'b1;
					saen_csa   <= 1'b0;
					clk_en_adc <= '0;
					{in0_wl, in1_wl, in0_bl, in1_bl, in0_sl, in1_sl} <= '1;
				end
			endcase
		end
	end

endmodule

// ==== source/rram_ctrl_top.sv ====
module rram_ctrl_top #(
	parameter int PROG_DEPTH = 64,
	parameter int IBUF_DEPTH = 16,
	parameter int RBUF_DEPTH = 64
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            bus_we,
	input  rram_pkg::word_t bus_addr,
	input  rram_pkg::word_t bus_wdata,
	output rram_pkg::word_t bus_rdata,
	input  logic            run,
	output logic            busy,
	output logic            done,
	input  rram_pkg::vec_t  csa,
	input  rram_pkg::vec_t  adc_out0,
	input  rram_pkg::vec_t  adc_out1,
	input  rram_pkg::vec_t  adc_out2,
	output logic            enable_csa,
	output logic            enable_adc,
	output logic            enable_wl,
	output logic            enable_sl,
	output logic            enable_bl,
	output logic            pre,
	output logic            saen_csa,
	output logic [1:0]      clk_en_adc,
	output rram_pkg::vec_t  in0_wl,
	output rram_pkg::vec_t  in1_wl,
	output rram_pkg::vec_t  in0_bl,
	output rram_pkg::vec_t  in1_bl,
	output rram_pkg::vec_t  in0_sl,
	output rram_pkg::vec_t  in1_sl
);
	import rram_pkg::*;

	logic [$clog2(PROG_DEPTH)-1:0] prog_addr;
	logic [$clog2(IBUF_DEPTH)-1:0] ibuf_addr;
	logic [$clog2(RBUF_DEPTH)-1:0] res_addr;
	word_t prog_data;
	word_t res_data;
	vec_t ibuf_data;
	vec_t wl_vec;
	logic res_we;
	logic set_bit;
	logic col_sel;
	logic [IDX_W-1:0] row;
	logic [IDX_W-1:0] col;
	phase_t phase;

	host_port #(.PROG_DEPTH(PROG_DEPTH), .IBUF_DEPTH(IBUF_DEPTH), .RBUF_DEPTH(RBUF_DEPTH)) u_host (
		.clk(clk), .rst(rst),
		.bus_we(bus_we), .bus_addr(bus_addr), .bus_wdata(bus_wdata), .bus_rdata(bus_rdata),
		.prog_addr(prog_addr), .prog_data(prog_data),
		.ibuf_addr(ibuf_addr), .ibuf_data(ibuf_data),
		.res_we(res_we), .res_addr(res_addr), .res_data(res_data)
	);

	array_sequencer #(
		.PROG_DEPTH(PROG_DEPTH), .IBUF_DEPTH(IBUF_DEPTH), .RBUF_DEPTH(RBUF_DEPTH)
	) u_seq (
		.clk(clk), .rst(rst), .run(run), .busy(busy), .done(done),
		.prog_addr(prog_addr), .prog_data(prog_data),
		.ibuf_addr(ibuf_addr), .ibuf_data(ibuf_data),
		.res_we(res_we), .res_addr(res_addr), .res_data(res_data),
		.csa(csa), .adc_out0(adc_out0), .adc_out1(adc_out1), .adc_out2(adc_out2),
		.phase(phase), .row(row), .col(col), .set_bit(set_bit),
		.wl_vec(wl_vec), .col_sel(col_sel)
	);

	line_driver u_lines (
		.clk(clk), .rst(rst),
		.phase(phase), .row(row), .col(col), .set_bit(set_bit),
		.wl_vec(wl_vec), .col_sel(col_sel),
		.enable_csa(enable_csa), .enable_adc(enable_adc), .enable_wl(enable_wl),
		.enable_sl(enable_sl), .enable_bl(enable_bl),
		.pre(pre), .saen_csa(saen_csa), .clk_en_adc(clk_en_adc),
		.in0_wl(in0_wl), .in1_wl(in1_wl), .in0_bl(in0_bl), .in1_bl(in1_bl),
		.in0_sl(in0_sl), .in1_sl(in1_sl)
	);

endmodule

// ==== verif/tb_clock.sv ====
module tb_clock #(
	parameter int PERIOD = 100
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD / 2) clk = ~clk;
		end
	end

endmodule

// ==== verif/rram_ctrl_props.sv ====
module rram_ctrl_props (
	input logic             clk,
	input logic             rst,
	input logic             busy,
	input logic             done,
	input logic             res_we,
	input rram_pkg::phase_t phase
);
	import rram_pkg::*;

	// Program end hands over from busy to done in one edge
	busy_done_excl: assert property (@(posedge clk) disable iff (!rst) !(busy && done))
		else $error("busy and done are high together");

	res_we_busy: assert property (@(posedge clk) disable iff (!rst) res_we |-> busy)
		else $error("result write outside a busy program");

	reset_idle: assert property (@(posedge clk) !rst |=> phase == PH_IDLE)
		else $error("sequencer not idle after reset");

endmodule

bind array_sequencer rram_ctrl_props u_props (
	.clk(clk),
	.rst(rst),
	.busy(busy),
	.done(done),
	.res_we(res_we),
	.phase(phase)
);

// ==== verif/tb_top.sv ====
module tb_top;
	import rram_pkg::*;

	localparam int NCASES = 14; // 0 read, 1..10 write, 11..12 MAC, 13 mixed
	localparam int MAXI = 6;
	localparam vec_t GND = '1; // Code 11 on every line

	logic clk;
	logic rst;
	logic bus_we;
	word_t bus_addr;
	word_t bus_wdata;
	word_t bus_rdata;
	logic run;
	logic busy;
	logic done;
	vec_t csa;
	vec_t adc_out0, adc_out1, adc_out2;
	logic enable_csa, enable_adc, enable_wl, enable_sl, enable_bl;
	logic pre;
	logic saen_csa;
	logic [1:0] clk_en_adc;
	vec_t in0_wl, in1_wl, in0_bl, in1_bl, in0_sl, in1_sl;

	word_t prog_tab [NCASES][MAXI];
	word_t exp_tab [NCASES][MAXI];
	vec_t vec_tab [NCASES][4];
	vec_t adc_tab [NCASES][3];
	vec_t csa_tab [NCASES];
	logic [3:0] row_tab [NCASES];
	logic [3:0] col_tab [NCASES];
	logic set_tab [NCASES];
	logic half_tab [NCASES];
	int n_prog [NCASES];
	int n_exp [NCASES];
	int n_vec [NCASES];
	int n_rd [NCASES];
	int n_wr [NCASES];

	int seed = 32'h104a_84a0;
	int errors = 0;
	int n_pass = 0;
	int cur = 0;
	int seen_read = 0;
	int seen_write = 0;
	int seen_mac = 0;
	int n_stored = 0;

	tb_clock #(.PERIOD(100)) u_clk (.clk(clk));

	rram_ctrl_top #(.PROG_DEPTH(64), .IBUF_DEPTH(16), .RBUF_DEPTH(64)) dut (.*);

	//////////////////////////////////////////////////////////////////////
	// Encoding and expected values

	function automatic word_t encode(opcode_t op, logic [3:0] row, logic [3:0] col, logic data);
		word_t w;
		w = '0;
		w[OPCODE_LSB +: 4] = op;
		w[ROW_LSB +: 4] = row;
		w[COL_LSB +: 4] = col;
		w[DATA_BIT] = data;
		return w;
	endfunction

	function automatic word_t encode_mac(logic [3:0] count, logic half);
		word_t w;
		w = '0;
		w[OPCODE_LSB +: 4] = OP_MAC;
		w[MAC_COUNT_LSB +: 4] = count;
		w[COL_SEL_BIT] = half;
		return w;
	endfunction

	// Nibble g holds ADC bit j = g + 8*half as {adc0, adc1, adc2, 1}
	function automatic word_t pack_adc(vec_t a0, vec_t a1, vec_t a2, logic half);
		word_t w;
		int j;
		w = '0;
		for (int g = 0; g < 8; g++) begin
			j = g + 8 * half;
			w = w | (word_t'({a0[j], a1[j], a2[j], 1'b1}) << (4 * g));
		end
		return w;
	endfunction

	task automatic add_instr(int c, word_t w, int results, word_t res);
		prog_tab[c][n_prog[c]] = w;
		n_prog[c]++;
		n_rd[c] += (w[OPCODE_LSB +: 4] == OP_READ);
		n_wr[c] += (w[OPCODE_LSB +: 4] == OP_WRITE);
		for (int i = 0; i < results; i++) begin
			exp_tab[c][n_exp[c]] = res;
			n_exp[c]++;
		end
	endtask

	task automatic build_table();
		logic half;
		logic [3:0] count;
		word_t mac_w;
		for (int c = 0; c < NCASES; c++) begin
			row_tab[c] = 4'($random(seed));
			col_tab[c] = 4'($random(seed));
			set_tab[c] = c[0];
			csa_tab[c] = 16'($random(seed));
			for (int k = 0; k < 3; k++) begin
				adc_tab[c][k] = 16'($random(seed));
			end
			for (int k = 0; k < 4; k++) begin
				vec_tab[c][k] = 16'($random(seed));
			end
			n_prog[c] = 0;
			n_exp[c] = 0;
			n_rd[c] = 0;
			n_wr[c] = 0;
			n_vec[c] = 0;
			half = (c == NCASES - 2) || ((c == NCASES - 1) && row_tab[c][0]);
			half_tab[c] = half;
			count = (c == NCASES - 1) ? 4'd1 : 4'd3;
			mac_w = pack_adc(adc_tab[c][0], adc_tab[c][1], adc_tab[c][2], half);
			if (c == 0 || c == NCASES - 1) begin
				add_instr(c, encode(OP_READ, row_tab[c], col_tab[c], 1'b0), 1, word_t'(csa_tab[c]));
			end
			if ((c > 0 && c < NCASES - 3) || c == NCASES - 1) begin
				add_instr(c, encode(OP_WRITE, row_tab[c], col_tab[c], set_tab[c]), 0, '0);
			end
			if (c >= NCASES - 3) begin
				add_instr(c, encode_mac(count, half), count + 1, mac_w);
				n_vec[c] = count + 1;
			end
			if (c == NCASES - 1) begin
				add_instr(c, encode(OP_READ, row_tab[c], col_tab[c], 1'b0), 1, word_t'(csa_tab[c]));
			end
			add_instr(c, encode(OP_IDLE, 4'd0, 4'd0, 1'b0), 0, '0);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Bus, run and checks

	task automatic check_value(word_t got, word_t exp, string what);
		if (got !== exp) begin
			$display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic bus_write(region_t region, int idx, word_t data);
		bus_we    = 1'b1;
		bus_addr  = (word_t'(region) << REGION_LSB) | word_t'(idx);
		bus_wdata = data;
		@(posedge clk);
		#10;
		bus_we = 1'b0;
	endtask

	task automatic run_program();
		run = 1'b1;
		@(posedge clk);
		#10;
		check_value(busy, 1, "busy after run rises");
		while (!done) begin
			@(posedge clk);
			#10;
		end
		check_value(busy, 0, "busy at done");
		run = 1'b0;
		@(posedge clk);
		#10;
		check_value(done, 0, "done after run falls");
	endtask

	task automatic run_case(int c);
		int err0;
		word_t marker;
		err0 = errors;
		cur = c;
		csa = csa_tab[c];
		adc_out0 = adc_tab[c][0];
		adc_out1 = adc_tab[c][1];
		adc_out2 = adc_tab[c][2];
		marker = $random(seed);
		if (c == 0) begin // Neighbour regions at the same index
			bus_write(REG_RESULT, 5, marker);
			bus_write(REG_INSTR, 5, ~marker);
			bus_write(REG_INPUT, 5, ~marker);
			bus_write(REG_NONE, 5, ~marker);
		end
		for (int i = 0; i < n_prog[c]; i++) begin
			bus_write(REG_INSTR, i, prog_tab[c][i]);
		end
		for (int k = 0; k < n_vec[c]; k++) begin
			bus_write(REG_INPUT, k, word_t'(vec_tab[c][k]));
		end
		seen_read = 0;
		seen_write = 0;
		seen_mac = 0;
		n_stored = 0;
		run_program();
		bus_addr = word_t'(REG_RESULT) << REGION_LSB;
		for (int i = 0; i < n_exp[c]; i++) begin
			@(posedge clk);
			#10;
			check_value(bus_rdata, exp_tab[c][i], $sformatf("case %0d result %0d", c, i));
			bus_addr = bus_addr + 1; // Next address while this one is checked
		end
		if (c == 0) begin
			bus_addr = (word_t'(REG_RESULT) << REGION_LSB) | 32'd5;
			@(posedge clk);
			#10;
			check_value(bus_rdata, marker, "result word beside host writes");
		end
		check_value(n_stored, n_exp[c], $sformatf("case %0d stored result count", c));
		check_value(seen_mac, n_vec[c], $sformatf("case %0d ADC conversion count", c));
		if ((n_rd[c] > 0) != (seen_read > 0) || (n_wr[c] > 0) != (seen_write > 0)) begin
			$display("Case %0d: line pattern of a READ or WRITE did not appear as expected", c);
			errors++;
		end
		n_pass += (errors == err0);
		$display("Case %0d %s", c, (errors == err0) ? "passed" : "failed");
	endtask

	// Array lines sampled between edges
	always @(negedge clk) begin : line_monitor
		vec_t row_low;
		vec_t col_low;
		vec_t wl_exp;
		row_low = ~(vec_t'(1) << row_tab[cur]);
		col_low = ~(vec_t'(1) << col_tab[cur]);
		n_stored += dut.res_we;
		if (enable_csa && !enable_wl) begin // Precharge cycle of a read
			check_value(pre, 1'b0, "read pre during precharge");
			check_value(saen_csa, 1'b1, "read saen_csa during precharge");
		end
		if (enable_wl && enable_csa) begin
			seen_read++;
			check_value(in0_wl, row_low, "read in0_wl");
			check_value(in1_wl, row_low, "read in1_wl");
			check_value(in0_bl, '0, "read in0_bl");
			check_value(enable_bl, 1'b1, "read enable_bl");
			check_value(pre, 1'b1, "read pre");
			check_value(saen_csa, 1'b1, "read saen_csa");
		end
		if (enable_wl && enable_sl && (in0_wl != GND)) begin
			seen_write++;
			check_value(in0_wl, row_low, "write in0_wl");
			check_value(in1_wl, GND, "write in1_wl");
			check_value(in0_bl, set_tab[cur] ? col_low : GND, "write in0_bl");
			check_value(in1_bl, set_tab[cur] ? col_low : GND, "write in1_bl");
			check_value(in0_sl, set_tab[cur] ? GND : col_low, "write in0_sl");
			check_value(in1_sl, GND, "write in1_sl");
		end
		if (clk_en_adc != 2'b00) begin // One ADC pulse per input vector
			wl_exp = ~vec_tab[cur][seen_mac[1:0]];
			check_value(clk_en_adc, half_tab[cur] ? 2'b10 : 2'b01, "mac clk_en_adc");
			check_value(enable_adc, 1'b1, "mac enable_adc");
			check_value(pre, 1'b1, "mac pre");
			check_value(in0_wl, wl_exp, "mac in0_wl");
			check_value(in1_wl, GND, "mac in1_wl");
			seen_mac++;
		end
	end

	initial begin
		#(NCASES * 2000);
		$display("Timeout, the cases did not finish in time");
		$display("Test FAILED");
		$finish;
	end

	initial begin
		rst = 1'b0;
		run = 1'b0;
		bus_we = 1'b0;
		bus_addr = '0;
		bus_wdata = '0;
		csa = '0;
		adc_out0 = '0;
		adc_out1 = '0;
		adc_out2 = '0;
		build_table();
		repeat (10) @(posedge clk);
		#10;
		rst = 1'b1;
		@(posedge clk);
		#10;
		for (int c = 0; c < NCASES; c++) begin
			run_case(c);
		end
		$display("%0d of %0d cases passed, %0d errors", n_pass, NCASES, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
source/rram_pkg.sv
source/word_ram.sv
source/host_port.sv
source/array_sequencer.sv
source/line_driver.sv
source/rram_ctrl_top.sv
verif/tb_clock.sv
verif/rram_ctrl_props.sv
verif/tb_top.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tb_top -o tb_sim \
	&& ./obj_dir/tb_sim | tee /dev/stderr | grep -x "Test OK" > /dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
